//--- mips_ex_defines.svh
//----------------------------------------------------------------------
// MIPS execute stage widths and constants
// Data path, register address and link return offset
//----------------------------------------------------------------------

`ifndef MIPS_EX_DEFINES_SVH
`define MIPS_EX_DEFINES_SVH

// Data path width
`define MIPS_XLEN 32

// Register number width, 32 architectural registers
`define MIPS_RAW 5

// Return address offset past the delay slot
`define MIPS_LINK_OFS 8

// Upper part of the R-type immediate view
`define MIPS_IMM_UPPER (`MIPS_XLEN - 11)

`endif

//--- mips_ex_pkg.sv
//----------------------------------------------------------------------
// MIPS execute stage types
// ALU encodings, immediate views, instruction and result bundles
//----------------------------------------------------------------------
`default_nettype none

`include "mips_ex_defines.svh"

package mips_ex_pkg;

	// Operation class from decode, same order as the old 4-bit field
	typedef enum logic [2:0] {
		CLS_ADD, CLS_SUB, CLS_RTYPE, CLS_AND, CLS_OR, CLS_SLT, CLS_LUI, CLS_ADDU
	} alu_class_e;

	// Concrete ALU operation
	typedef enum logic [3:0] {
		OP_ADD = 4'd0, OP_SUB = 4'd1, OP_AND = 4'd2, OP_OR = 4'd3,
		OP_XOR = 4'd4, OP_NOR = 4'd5, OP_SLT = 4'd6, OP_SLL = 4'd10,
		OP_SRL = 4'd11, OP_SRA = 4'd12, OP_LUI = 4'd13, OP_BAD = 4'd15
	} alu_op_e;

	typedef enum logic [1:0] {FWD_REG = 2'd0, FWD_WB = 2'd1, FWD_MEM = 2'd2} fwd_sel_e;

	// Same word seen as plain immediate or as R-type shamt/funct
	typedef union packed {
		logic [`MIPS_XLEN-1:0] raw;          // Sign-extended immediate
		struct packed {
			logic [`MIPS_IMM_UPPER-1:0] upper;
			logic [4:0] shamt;                // Bits 10..6
			logic [5:0] funct;                // Bits 5..0
		} r;
	} imm_word_u;

	typedef struct packed {
		logic link;          // Operands are pc and the link offset
		logic reg_dst;       // Write rd instead of rt
		logic alu_src;       // Immediate on operand B
		logic shamt_src;     // Shamt on operand A
		alu_class_e cls;
	} ex_ctrl_t;

	typedef struct packed {
		logic [`MIPS_XLEN-1:0] pc;
		logic [`MIPS_RAW-1:0] rs;
		logic [`MIPS_RAW-1:0] rt;
		logic [`MIPS_RAW-1:0] rd;
		logic [`MIPS_XLEN-1:0] data_1;   // Register file read of rs
		logic [`MIPS_XLEN-1:0] data_2;   // Register file read of rt
		imm_word_u imm;
		ex_ctrl_t ctrl;
		logic reg_write;
	} ex_instr_t;

	typedef struct packed {
		logic [`MIPS_XLEN-1:0] pc;
		logic [`MIPS_RAW-1:0] dest;
		logic [`MIPS_XLEN-1:0] res;
		logic zero;
		logic over;
		logic reg_write;
	} ex_result_t;

	// What a later stage offers back to the operand muxes
	typedef struct packed {
		logic valid;
		logic reg_write;
		logic [`MIPS_RAW-1:0] dest;
		logic [`MIPS_XLEN-1:0] res;
	} fwd_src_t;

endpackage

`default_nettype wire

//--- mips_forward_unit.sv
//----------------------------------------------------------------------
// Forwarding unit, picks the newest producer for each ALU operand
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "mips_ex_defines.svh"

module mips_forward_unit
	import mips_ex_pkg::*;
(
	input wire logic [`MIPS_RAW-1:0] rs,
	input wire logic [`MIPS_RAW-1:0] rt,
	input wire fwd_src_t mem_src,     // One instruction ahead
	input wire fwd_src_t wb_src,      // Two instructions ahead
	output fwd_sel_e fwd_a,
	output fwd_sel_e fwd_b
);

	// Live producer writing this register, r0 excluded
	function automatic logic hit(input fwd_src_t src, input logic [`MIPS_RAW-1:0] r);
		return src.valid && src.reg_write && (src.dest != '0) && (src.dest == r);
	endfunction

	// EX/MEM wins over WB, it holds the younger value
	function automatic fwd_sel_e pick(input fwd_src_t m, input fwd_src_t w,
		input logic [`MIPS_RAW-1:0] r);
		if (hit(m, r))
			return FWD_MEM;
		else if (hit(w, r))
			return FWD_WB;
		else
			return FWD_REG;
	endfunction

	assign fwd_a = pick(mem_src, wb_src, rs);
	assign fwd_b = pick(mem_src, wb_src, rt);

endmodule

`default_nettype wire

//--- mips_alu_ctrl.sv
//----------------------------------------------------------------------
// ALU control, operation class plus funct to concrete ALU operation
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module mips_alu_ctrl
	import mips_ex_pkg::*;
(
	input wire alu_class_e cls,
	input wire logic [5:0] funct,
	output alu_op_e op
);

	always_comb
	begin
		case (cls)
			CLS_ADD,
			CLS_ADDU: op = OP_ADD;     // Immediate add, trap decided elsewhere
			CLS_SUB: op = OP_SUB;
			CLS_AND: op = OP_AND;
			CLS_OR: op = OP_OR;
			CLS_SLT: op = OP_SLT;
			CLS_LUI: op = OP_LUI;
			CLS_RTYPE:
			begin
				case (funct)
					6'd0, 6'd4: op = OP_SLL;     // sll / sllv
					6'd2, 6'd6: op = OP_SRL;     // srl / srlv
					6'd3, 6'd7: op = OP_SRA;     // sra / srav
					6'd32, 6'd33: op = OP_ADD;   // add / addu
					6'd34: op = OP_SUB;
					6'd36: op = OP_AND;
					6'd37: op = OP_OR;
					6'd38: op = OP_XOR;
					6'd39: op = OP_NOR;
					6'd42: op = OP_SLT;
					default: op = OP_BAD;        // Unknown funct
				endcase
			end
			default: op = OP_BAD;
		endcase
	end

endmodule

`default_nettype wire

//--- mips_alu.sv
//----------------------------------------------------------------------
// Integer ALU with zero flag and trapping signed overflow
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "mips_ex_defines.svh"

module mips_alu
	import mips_ex_pkg::*;
(
	input wire logic [`MIPS_XLEN-1:0] a,
	input wire logic [`MIPS_XLEN-1:0] b,
	input wire alu_op_e op,
	input wire logic trap_ovf,      // Signed add/sub only
	output logic [`MIPS_XLEN-1:0] res,
	output logic zero,
	output logic over
);

	localparam int MSB = `MIPS_XLEN - 1;

	logic [`MIPS_XLEN-1:0] sum;
	logic [`MIPS_XLEN-1:0] diff;
	logic [4:0] sh;
	logic add_ovf;
	logic sub_ovf;

	assign sum = a + b;
	assign diff = a - b;
	assign sh = a[4:0];      // Shift count, shamt or rs

	// Same-sign inputs giving a flipped sign
	assign add_ovf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
	// Opposite-sign inputs, sign of a lost
	assign sub_ovf = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);

	always_comb
	begin
		case (op)
			OP_ADD: res = sum;
			OP_SUB: res = diff;
			OP_AND: res = a & b;
			OP_OR: res = a | b;
			OP_XOR: res = a ^ b;
			OP_NOR: res = ~(a | b);
			OP_SLT: res = {{MSB{1'b0}}, $signed(a) < $signed(b)};
			OP_SLL: res = b << sh;
			OP_SRL: res = b >> sh;
			OP_SRA: res = $signed(b) >>> sh;   // Sign fill
			OP_LUI: res = b << 16;
			default: res = '0;                 // BAD
		endcase
	end

	assign zero = (res == '0);
	assign over = trap_ovf && (((op == OP_ADD) && add_ovf) || ((op == OP_SUB) && sub_ovf));

endmodule

`default_nettype wire

//--- mips_ex_stage.sv
//----------------------------------------------------------------------
// Execute stage, operand forwarding and select, ALU, EX/MEM register
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "mips_ex_defines.svh"

module mips_ex_stage
	import mips_ex_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire ex_instr_t in,
	input wire logic in_valid,
	input wire logic flush_ex,
	input wire logic advance,       // Global pipeline step
	input wire fwd_src_t wb_src,
	output ex_result_t mem_q,
	output logic mem_valid,
	output fwd_src_t mem_src
);

	fwd_sel_e fwd_a;
	fwd_sel_e fwd_b;
	logic [`MIPS_XLEN-1:0] rs_val;
	logic [`MIPS_XLEN-1:0] rt_val;
	logic [`MIPS_XLEN-1:0] op_a;
	logic [`MIPS_XLEN-1:0] op_b;
	alu_op_e dec_op;
	alu_op_e alu_op;
	logic trap_ovf;
	logic [`MIPS_XLEN-1:0] alu_res;
	logic alu_zero;
	logic alu_over;
	ex_result_t result;

	// Producer value for one operand
	function automatic logic [`MIPS_XLEN-1:0] fwd_value(input fwd_sel_e sel,
		input logic [`MIPS_XLEN-1:0] reg_val, input logic [`MIPS_XLEN-1:0] mem_val,
		input logic [`MIPS_XLEN-1:0] wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	//------------------------------------------------------------------
	// Hazards and operands
	//------------------------------------------------------------------
	mips_forward_unit mips_forward_unit_i (.rs(in.rs), .rt(in.rt), .mem_src(mem_src),
		.wb_src(wb_src), .fwd_a(fwd_a), .fwd_b(fwd_b));

	assign rs_val = fwd_value(fwd_a, in.data_1, mem_src.res, wb_src.res);
	assign rt_val = fwd_value(fwd_b, in.data_2, mem_src.res, wb_src.res);

	always_comb
	begin
		if (in.ctrl.link)
		begin
			op_a = in.pc;                             // Return address is pc + 8
			op_b = `MIPS_XLEN'(`MIPS_LINK_OFS);
		end
		else
		begin
			op_a = in.ctrl.shamt_src ? `MIPS_XLEN'(in.imm.r.shamt) : rs_val;
			op_b = in.ctrl.alu_src ? in.imm.raw : rt_val;
		end
	end

	//------------------------------------------------------------------
	// ALU
	//------------------------------------------------------------------
	mips_alu_ctrl mips_alu_ctrl_i (.cls(in.ctrl.cls), .funct(in.imm.r.funct), .op(dec_op));

	assign alu_op = in.ctrl.link ? OP_ADD : dec_op;    // Link always adds
	// Only add and sub trap, addu/addi style never do
	assign trap_ovf = !in.ctrl.link && (in.ctrl.cls == CLS_RTYPE) &&
		((in.imm.r.funct == 6'd32) || (in.imm.r.funct == 6'd34));

	mips_alu mips_alu_i (.a(op_a), .b(op_b), .op(alu_op), .trap_ovf(trap_ovf),
		.res(alu_res), .zero(alu_zero), .over(alu_over));

	always_comb
	begin
		result.pc = in.pc;
		result.dest = (in.ctrl.link || in.ctrl.reg_dst) ? in.rd : in.rt;
		result.res = alu_res;
		result.zero = alu_zero;
		result.over = alu_over;
		result.reg_write = in.reg_write;
	end

	//------------------------------------------------------------------
	// EX/MEM register
	//------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			mem_valid <= 1'b0;
		else if (advance)
			mem_valid <= in_valid && !flush_ex;   // Flush or no input gives a bubble
	end

	always_ff @(posedge clk)
	begin
		if (advance)
			mem_q <= result;
	end

	assign mem_src = '{valid: mem_valid, reg_write: mem_q.reg_write, dest: mem_q.dest,
		res: mem_q.res};

endmodule

`default_nettype wire

//--- mips_wb_stage.sv
//----------------------------------------------------------------------
// Write-back register, holds the retiring result for the output
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module mips_wb_stage
	import mips_ex_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire ex_result_t mem_q,
	input wire logic mem_valid,
	input wire logic advance,
	output ex_result_t out,
	output logic out_valid,
	output fwd_src_t wb_src
);

	// Valid tracks the pipe, bubbles pass through as low
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (advance)
			out_valid <= mem_valid;
	end

	always_ff @(posedge clk)
	begin
		if (advance)
			out <= mem_q;    // Held while stalled
	end

	// Second forwarding source, stays valid under back-pressure
	assign wb_src = '{valid: out_valid, reg_write: out.reg_write, dest: out.dest,
		res: out.res};

endmodule

`default_nettype wire

//--- mips_ex_top.sv
//----------------------------------------------------------------------
// Execute plus write-back with a single global advance
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module mips_ex_top
	import mips_ex_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire ex_instr_t in,
	input wire logic in_valid,
	input wire logic flush_ex,
	input wire logic out_ready,
	output logic in_ready,
	output ex_result_t out,
	output logic out_valid
);

	logic advance;
	ex_result_t mem_q;
	logic mem_valid;
	fwd_src_t mem_src;
	fwd_src_t wb_src;

	// Step when WB is empty or its result leaves this cycle
	assign advance = !out_valid || out_ready;
	assign in_ready = advance;

	mips_ex_stage mips_ex_stage_i (.clk(clk), .rst_n(rst_n), .in(in), .in_valid(in_valid),
		.flush_ex(flush_ex), .advance(advance), .wb_src(wb_src), .mem_q(mem_q),
		.mem_valid(mem_valid), .mem_src(mem_src));

	mips_wb_stage mips_wb_stage_i (.clk(clk), .rst_n(rst_n), .mem_q(mem_q),
		.mem_valid(mem_valid), .advance(advance), .out(out), .out_valid(out_valid),
		.wb_src(wb_src));

endmodule

`default_nettype wire

//--- mips_ex_checker.sv
//----------------------------------------------------------------------
// Execute stage checker, program-order reference model and scoreboard
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "mips_ex_defines.svh"

module mips_ex_checker
	import mips_ex_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire ex_instr_t in,
	input wire logic in_valid,
	input wire logic in_ready,
	input wire logic flush_ex,
	input wire ex_result_t out,
	input wire logic out_valid,
	input wire logic out_ready
);

	localparam longint S_MAX = 64'sd2147483647;    // Signed 32-bit range
	localparam longint S_MIN = -64'sd2147483648;

	logic [`MIPS_XLEN-1:0] arch [32];    // Architectural registers, program order
	ex_result_t exp_q [$];               // Expected retirements, oldest first
	string cur_test = "idle";
	int outstanding = 0;
	int test_checks = 0;
	int test_errors = 0;
	int n_tests = 0;
	int n_failed = 0;
	int total_checks = 0;
	int total_errors = 0;

	initial
	begin
		for (int k = 0; k < 32; k++)
			arch[k] = '0;
	end

	// Expected result of one instruction given the current register values
	function automatic ex_result_t ref_exec(input ex_instr_t i,
		input logic [`MIPS_XLEN-1:0] rs_v, input logic [`MIPS_XLEN-1:0] rt_v);
		ex_result_t r;
		logic [`MIPS_XLEN-1:0] a;
		logic [`MIPS_XLEN-1:0] b;
		longint wide;
		logic trap;
		a = i.ctrl.shamt_src ? `MIPS_XLEN'(i.imm.r.shamt) : rs_v;
		b = i.ctrl.alu_src ? i.imm.raw : rt_v;
		wide = 0;
		trap = 1'b0;
		r = '0;
		if (i.ctrl.link)
			r.res = i.pc + `MIPS_LINK_OFS;     // Return address
		else
		begin
			case (i.ctrl.cls)
				CLS_ADD, CLS_ADDU: r.res = a + b;
				CLS_SUB: r.res = a - b;
				CLS_AND: r.res = a & b;
				CLS_OR: r.res = a | b;
				CLS_SLT: r.res = ($signed(a) < $signed(b)) ? 1 : 0;
				CLS_LUI: r.res = {b[15:0], 16'h0000};
				CLS_RTYPE:
				begin
					case (i.imm.r.funct)
						6'd0, 6'd4: r.res = b << a[4:0];
						6'd2, 6'd6: r.res = b >> a[4:0];
						6'd3, 6'd7: r.res = $signed(b) >>> a[4:0];
						6'd32:
						begin
							r.res = a + b;
							wide = longint'($signed(a)) + longint'($signed(b));
							trap = 1'b1;
						end
						6'd33: r.res = a + b;          // addu never traps
						6'd34:
						begin
							r.res = a - b;
							wide = longint'($signed(a)) - longint'($signed(b));
							trap = 1'b1;
						end
						6'd36: r.res = a & b;
						6'd37: r.res = a | b;
						6'd38: r.res = a ^ b;
						6'd39: r.res = ~(a | b);
						6'd42: r.res = ($signed(a) < $signed(b)) ? 1 : 0;
						default: r.res = '0;           // Unknown funct
					endcase
				end
				default: r.res = '0;
			endcase
		end
		r.over = trap && ((wide > S_MAX) || (wide < S_MIN));   // Out of 32-bit range
		r.zero = (r.res == '0);
		r.dest = (i.ctrl.link || i.ctrl.reg_dst) ? i.rd : i.rt;
		r.pc = i.pc;
		r.reg_write = i.reg_write;
		return r;
	endfunction

	task automatic note_failure(input string msg);
		$display("%s: %s", cur_test, msg);
		test_errors++;
		total_errors++;
	endtask

	// Accepted, unflushed instruction enters the expected queue
	task automatic capture();
		ex_result_t e;
		e = ref_exec(in, arch[in.rs], arch[in.rt]);
		if (e.reg_write && (e.dest != '0))
			arch[e.dest] = e.res;                // r0 stays zero
		exp_q.push_back(e);
		outstanding++;
	endtask

	task automatic compare();
		ex_result_t e;
		string exp_s;
		string act_s;
		if (exp_q.size() == 0)
			note_failure("a result retired with no instruction outstanding");
		else
		begin
			e = exp_q.pop_front();
			outstanding--;
			test_checks++;
			total_checks++;
			if (out !== e)
			begin
				exp_s = $sformatf("pc %h dest %0d res %h zero %b over %b wr %b",
					e.pc, e.dest, e.res, e.zero, e.over, e.reg_write);
				act_s = $sformatf("pc %h dest %0d res %h zero %b over %b wr %b",
					out.pc, out.dest, out.res, out.zero, out.over, out.reg_write);
				$display("ERR %s: expected %s, actual %s", cur_test, exp_s, act_s);
				test_errors++;
				total_errors++;
			end
		end
	endtask

	//------------------------------------------------------------------
	// Watch both handshakes
	//------------------------------------------------------------------
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			if (out_valid && out_ready)
				compare();
			if (in_valid && in_ready && !flush_ex)
				capture();
			if (out_valid && !out_ready && in_ready)
				note_failure("in_ready was high while the output was stalled");
		end
	end

	task automatic begin_test(input string name);
		cur_test = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic end_test();
		n_tests++;
		if (test_errors != 0)
			n_failed++;
		$display("%s %s: %0d results checked, %0d errors", (test_errors == 0) ? "PASS" : "FAIL",
			cur_test, test_checks, test_errors);
	endtask

	task automatic report();
		if (outstanding != 0)
			note_failure($sformatf("%0d instructions were accepted but never retired",
				outstanding));
		$display("%0d tests run, %0d with errors, %0d results checked, %0d errors total",
			n_tests, n_failed, total_checks, total_errors);
	endtask

endmodule

`default_nettype wire

//--- mips_ex_tb.sv
//----------------------------------------------------------------------
// Execute stage testbench, clock, reset, register file model, stimulus
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "mips_ex_defines.svh"

module mips_ex_tb
	import mips_ex_pkg::*;
();

	// setup 31, rtype 64, imm 14, chains 21, flush 9, random 40, shift 13
	localparam int N_INSTR = 192;
	localparam int WATCHDOG_CYCLES = N_INSTR * 20 + 100;

	logic clk;
	logic rst_n;
	ex_instr_t in;
	logic in_valid;
	logic flush_ex;
	logic out_ready;
	logic in_ready;
	ex_result_t out;
	logic out_valid;

	logic [`MIPS_XLEN-1:0] rf [32];      // Register file, written at retire only
	logic [`MIPS_XLEN-1:0] pc;
	integer seed;
	integer ready_seed;                  // Separate stream for out_ready
	logic random_ready;

	mips_ex_top mips_ex_top_i (.clk(clk), .rst_n(rst_n), .in(in), .in_valid(in_valid),
		.flush_ex(flush_ex), .out_ready(out_ready), .in_ready(in_ready), .out(out),
		.out_valid(out_valid));

	mips_ex_checker checker_i (.clk(clk), .rst_n(rst_n), .in(in), .in_valid(in_valid),
		.in_ready(in_ready), .flush_ex(flush_ex), .out(out), .out_valid(out_valid),
		.out_ready(out_ready));

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Retired results become visible to later reads
	always @(posedge clk)
	begin
		if (rst_n && out_valid && out_ready && out.reg_write && (out.dest != '0))
			rf[out.dest] <= out.res;
	end

	// Output back-pressure, random only in the random test
	initial
	begin
		ready_seed = 32'hea148123;
		out_ready = 1'b1;
		forever
		begin
			@(posedge clk);
			#1;
			out_ready = random_ready ? 1'($random(ready_seed)) : 1'b1;
		end
	end

	//------------------------------------------------------------------
	// Instruction builders
	//------------------------------------------------------------------
	function automatic logic [4:0] rand_reg();
		return 5'(1 + ($unsigned($random(seed)) % 31));      // Never r0
	endfunction

	function automatic logic [`MIPS_XLEN-1:0] sext16(input logic [`MIPS_XLEN-1:0] v);
		return {{16{v[15]}}, v[15:0]};
	endfunction

	function automatic ex_instr_t rtype(input logic [5:0] funct, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] shamt);
		ex_instr_t i;
		i = '0;
		i.rs = rs;
		i.rt = rt;
		i.rd = rd;
		i.imm.r.shamt = shamt;
		i.imm.r.funct = funct;
		i.ctrl.cls = CLS_RTYPE;
		i.ctrl.reg_dst = 1'b1;
		i.ctrl.shamt_src = (funct < 6'd4);     // sll, srl, sra use shamt
		i.reg_write = 1'b1;
		return i;
	endfunction

	function automatic ex_instr_t itype(input alu_class_e cls, input logic [4:0] rt,
		input logic [4:0] rs, input logic [`MIPS_XLEN-1:0] imm);
		ex_instr_t i;
		i = '0;
		i.rs = rs;
		i.rt = rt;
		i.imm.raw = imm;
		i.ctrl.cls = cls;
		i.ctrl.alu_src = 1'b1;
		i.reg_write = 1'b1;
		return i;
	endfunction

	function automatic ex_instr_t link_instr(input logic [4:0] rd);
		ex_instr_t i;
		i = '0;
		i.rd = rd;
		i.ctrl.link = 1'b1;
		i.reg_write = 1'b1;
		return i;
	endfunction

	function automatic ex_instr_t rand_instr();
		ex_instr_t i;
		i = '0;
		i.rs = 5'($random(seed));
		i.rt = 5'($random(seed));
		i.rd = 5'($random(seed));
		i.imm.raw = $random(seed);
		i.ctrl = ex_ctrl_t'(7'($random(seed)));
		i.reg_write = 1'b1;
		return i;
	endfunction

	//------------------------------------------------------------------
	// Issue and test sequencing
	//------------------------------------------------------------------
	// Operands read from the model now, stale for the two in flight
	task automatic issue(input ex_instr_t ins, input logic flush);
		ins.pc = pc;
		ins.data_1 = rf[ins.rs];
		ins.data_2 = rf[ins.rt];
		pc = pc + 4;
		in = ins;
		in_valid = 1'b1;
		flush_ex = flush;
		@(posedge clk);
		while (!in_ready)
			@(posedge clk);
		#1;
		in_valid = 1'b0;
		flush_ex = 1'b0;
	endtask

	task automatic start(input string name);
		@(posedge clk);
		#1;
		checker_i.begin_test(name);
	endtask

	// Wait until every accepted instruction has retired
	task automatic close_test();
		#2;
		while (checker_i.outstanding != 0)
		begin
			@(posedge clk);
			#2;
		end
		checker_i.end_test();
	endtask

	initial
	begin
		integer k;
		integer d;
		seed = 32'hea148123;
		random_ready = 1'b0;
		pc = 32'h0040_0000;
		for (k = 0; k < 32; k++)
			rf[k] = '0;
		in = '0;
		in_valid = 1'b0;
		flush_ex = 1'b0;
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;

		start("setup");
		for (k = 1; k < 32; k++)
			issue(itype(CLS_OR, 5'(k), 5'd0, $random(seed)), 1'b0);
		close_test();

		start("rtype_funct");
		for (k = 0; k < 64; k++)                 // Every funct, unknown ones too
			issue(rtype(6'(k), rand_reg(), rand_reg(), rand_reg(), 5'($random(seed))), 1'b0);
		close_test();

		start("imm_classes");
		for (k = 0; k < 2; k++)
		begin
			issue(itype(CLS_ADD, rand_reg(), rand_reg(), sext16($random(seed))), 1'b0);
			issue(itype(CLS_ADDU, rand_reg(), rand_reg(), sext16($random(seed))), 1'b0);
			issue(itype(CLS_AND, rand_reg(), rand_reg(), sext16($random(seed))), 1'b0);
			issue(itype(CLS_OR, rand_reg(), rand_reg(), sext16($random(seed))), 1'b0);
			issue(itype(CLS_SLT, rand_reg(), rand_reg(), sext16($random(seed))), 1'b0);
			issue(itype(CLS_LUI, rand_reg(), rand_reg(), sext16($random(seed))), 1'b0);
			issue(link_instr(5'd31), 1'b0);
		end
		close_test();

		start("dep_chains");
		for (d = 1; d <= 3; d++)                 // Producer d instructions ahead
			for (k = 0; k < 6; k++)
				issue(rtype(6'd33, 5'(10 + k), (k >= d) ? 5'(10 + k - d) : 5'd1, 5'd2, 5'd0),
					1'b0);
		issue(itype(CLS_OR, 5'd0, 5'd0, 32'h0000_5a5a), 1'b0);    // Write to r0
		issue(rtype(6'd33, 5'd5, 5'd0, 5'd0, 5'd0), 1'b0);
		issue(rtype(6'd37, 5'd6, 5'd0, 5'd3, 5'd0), 1'b0);
		close_test();

		start("flush");
		for (k = 0; k < 3; k++)
		begin
			issue(itype(CLS_OR, 5'd7, 5'd0, 32'h100 + k), 1'b0);
			issue(itype(CLS_OR, 5'd7, 5'd0, 32'hdead_0000), 1'b1);  // Turned into a bubble
			issue(rtype(6'd33, 5'(8 + k), 5'd7, 5'd0, 5'd0), 1'b0);
		end
		close_test();

		random_ready = 1'b1;
		start("random_ready");
		for (k = 0; k < 40; k++)
			issue(rand_instr(), 1'b0);
		close_test();
		random_ready = 1'b0;

		start("shift_overflow");
		issue(itype(CLS_OR, 5'd20, 5'd0, 32'h7fff_ffff), 1'b0);
		issue(itype(CLS_OR, 5'd21, 5'd0, 32'h0000_0001), 1'b0);
		issue(itype(CLS_OR, 5'd22, 5'd0, 32'h8000_0000), 1'b0);
		issue(rtype(6'd32, 5'd23, 5'd20, 5'd21, 5'd0), 1'b0);   // add overflows
		issue(rtype(6'd33, 5'd24, 5'd20, 5'd21, 5'd0), 1'b0);   // addu never flags
		issue(rtype(6'd34, 5'd25, 5'd22, 5'd21, 5'd0), 1'b0);   // sub overflows
		issue(rtype(6'd34, 5'd26, 5'd21, 5'd21, 5'd0), 1'b0);   // Zero result
		issue(itype(CLS_ADD, 5'd27, 5'd20, 32'd1), 1'b0);       // Immediate add, no trap
		issue(rtype(6'd3, 5'd28, 5'd0, 5'd22, 5'd4), 1'b0);
		issue(rtype(6'd7, 5'd29, 5'd21, 5'd22, 5'd0), 1'b0);
		issue(rtype(6'd0, 5'd30, 5'd0, 5'd21, 5'd31), 1'b0);
		issue(rtype(6'd2, 5'd19, 5'd0, 5'd22, 5'd0), 1'b0);
		issue(rtype(6'd6, 5'd18, 5'd20, 5'd22, 5'd0), 1'b0);    // Shift by 31 from rs
		close_test();

		checker_i.report();
		if (checker_i.total_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Watchdog, scaled to the instruction count
	initial
	begin
		#(WATCHDOG_CYCLES * 10);
		$display("Watchdog expired with %0d results still outstanding",
			checker_i.outstanding);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- mips_ex.f
+incdir+.
mips_ex_pkg.sv
mips_forward_unit.sv
mips_alu_ctrl.sv
mips_alu.sv
mips_ex_stage.sv
mips_wb_stage.sv
mips_ex_top.sv
mips_ex_checker.sv
mips_ex_tb.sv

//--- Bender.yml
package:
  name: mips_ex

export_include_dirs:
  - .

sources:
  - mips_ex_pkg.sv
  - mips_forward_unit.sv
  - mips_alu_ctrl.sv
  - mips_alu.sv
  - mips_ex_stage.sv
  - mips_wb_stage.sv
  - mips_ex_top.sv
  - target: test
    files:
      - mips_ex_checker.sv
      - mips_ex_tb.sv
